// ==== dvbs2_mod.f ====
source/dvbs2_pkg.sv
source/ts_crc_ingest.sv
source/pkt_buffer.sv
source/qpsk_mapper.sv
source/dvbs2_mod_top.sv
tb/tb_dvbs2_mod.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dvbs2_mod -f dvbs2_mod.f -o sim_dvbs2_mod

./obj_dir/sim_dvbs2_mod 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
if ! grep -q "test passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation ok"

// ==== source/dvbs2_mod_top.sv ====
`timescale 1ns/1ps

module dvbs2_mod_top (
	input  logic                  mpeg_clk,
	input  logic                  rst_n,
	input  dvbs2_pkg::ts_in_t     ts_in,
	output dvbs2_pkg::iq_symbol_t symbol,
	output logic                  symbol_oe
);
	import dvbs2_pkg::*;

	mem_req_t wr_req;
	mem_rsp_t wr_rsp;
	mem_req_t rd_req;
	mem_rsp_t rd_rsp;
	logic     pkt_stored;

	ts_crc_ingest u_ingest (
		.mpeg_clk   (mpeg_clk),
		.rst_n      (rst_n),
		.ts_in      (ts_in),
		.wr_req     (wr_req),
		.wr_rsp     (wr_rsp),
		.pkt_stored (pkt_stored)
	);

	pkt_buffer u_buffer (
		.mpeg_clk (mpeg_clk),
		.rst_n    (rst_n),
		.wr_req   (wr_req),
		.wr_rsp   (wr_rsp),
		.rd_req   (rd_req),
		.rd_rsp   (rd_rsp)
	);

	qpsk_mapper u_mapper (
		.mpeg_clk   (mpeg_clk),
		.rst_n      (rst_n),
		.pkt_stored (pkt_stored),
		.rd_req     (rd_req),
		.rd_rsp     (rd_rsp),
		.symbol     (symbol),
		.symbol_oe  (symbol_oe)
	);

endmodule

// ==== source/dvbs2_pkg.sv ====
package dvbs2_pkg;

	// ts packet and buffer geometry
	localparam int PKT_BYTES = 188;
	localparam int BUF_PKTS  = 2;
	localparam int BUF_DEPTH = PKT_BYTES * BUF_PKTS;
	localparam int ADDR_W    = 9;

	// x^8+x^7+x^6+x^4+x^2+1, msb first
	localparam logic [7:0] CRC8_POLY = 8'hD5;

	// 1/sqrt(2) scaled, same level on both rails
	localparam logic signed [15:0] QPSK_POS = 16'sh0B50;
	localparam logic signed [15:0] QPSK_NEG = -16'sh0B50;

	// one input ts byte
	typedef struct packed {
		logic       valid;
		logic       sync;
		logic [7:0] data;
	} ts_in_t;

	// request from one buffer peer
	typedef struct packed {
		logic              req;
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        wdata;
	} mem_req_t;

	// response to one buffer peer
	typedef struct packed {
		logic       gnt;
		logic       rvalid;
		logic [7:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic signed [15:0] re;
		logic signed [15:0] im;
	} iq_symbol_t;

endpackage

// ==== source/pkt_buffer.sv ====
`timescale 1ns/1ps

module pkt_buffer (
	input  logic                mpeg_clk,
	input  logic                rst_n,
	input  dvbs2_pkg::mem_req_t wr_req,
	output dvbs2_pkg::mem_rsp_t wr_rsp,
	input  dvbs2_pkg::mem_req_t rd_req,
	output dvbs2_pkg::mem_rsp_t rd_rsp
);
	import dvbs2_pkg::*;

	logic [7:0] mem [BUF_DEPTH];
	logic       wr_gnt;
	logic       rd_gnt;
	mem_req_t   sel;
	logic [7:0] rdata_q;
	logic       wr_rvalid_q;
	logic       rd_rvalid_q;

	// fixed priority, writer first
	assign wr_gnt = wr_req.req;
	assign rd_gnt = rd_req.req & ~wr_req.req;
	assign sel    = wr_gnt ? wr_req : rd_req;

	// single port, one access per cycle
	always_ff @(posedge mpeg_clk) begin
		if (wr_gnt || rd_gnt) begin
			if (sel.we) begin
				mem[sel.addr] <= sel.wdata;
			end else begin
				rdata_q <= mem[sel.addr];
			end
		end
	end

	// read data valid one cycle after grant
	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			wr_rvalid_q <= 1'b0;
			rd_rvalid_q <= 1'b0;
		end else begin
			wr_rvalid_q <= wr_gnt & ~wr_req.we;
			rd_rvalid_q <= rd_gnt & ~rd_req.we;
		end
	end

	always_comb begin
		wr_rsp.gnt    = wr_gnt;
		wr_rsp.rvalid = wr_rvalid_q;
		wr_rsp.rdata  = rdata_q;
	end

	always_comb begin
		rd_rsp.gnt    = rd_gnt;
		rd_rsp.rvalid = rd_rvalid_q;
		rd_rsp.rdata  = rdata_q;
	end

	a_addr_in_range: assert property (@(posedge mpeg_clk) disable iff (!rst_n)
		(wr_gnt || rd_gnt) |-> (sel.addr < ADDR_W'(BUF_DEPTH)));

endmodule

// ==== source/qpsk_mapper.sv ====
`timescale 1ns/1ps

module qpsk_mapper (
	input  logic                  mpeg_clk,
	input  logic                  rst_n,
	input  logic                  pkt_stored,
	output dvbs2_pkg::mem_req_t   rd_req,
	input  dvbs2_pkg::mem_rsp_t   rd_rsp,
	output dvbs2_pkg::iq_symbol_t symbol,
	output logic                  symbol_oe
);
	import dvbs2_pkg::*;

	logic [1:0]        pend_cnt;
	logic [ADDR_W-1:0] rd_addr;
	logic              rd_fire;
	logic              rd_last;
	logic [7:0]        q_data;
	logic              q_valid;
	logic [7:0]        sh_byte;
	logic [1:0]        sh_phase;
	logic              sh_valid;
	logic              sh_load;

	assign rd_fire = rd_req.req & rd_rsp.gnt;
	// last byte of either slot
	assign rd_last = (rd_addr == ADDR_W'(PKT_BYTES - 1)) ||
		(rd_addr == ADDR_W'(BUF_DEPTH - 1));
	assign sh_load = !sh_valid || (sh_phase == 2'd3);

	// fetch only with room in the queue and nothing in flight
	always_comb begin
		rd_req.req   = (pend_cnt != 2'd0) && !q_valid && !rd_rsp.rvalid;
		rd_req.we    = 1'b0;
		rd_req.addr  = rd_addr;
		rd_req.wdata = 8'h00;
	end

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			pend_cnt <= 2'd0;
			rd_addr  <= '0;
		end else begin
			pend_cnt <= pend_cnt + {1'b0, pkt_stored} - {1'b0, rd_fire & rd_last};
			if (rd_fire) begin
				rd_addr <= (rd_addr == ADDR_W'(BUF_DEPTH - 1)) ? '0 : rd_addr + 1'b1;
			end
		end
	end

	// shifter takes the queued byte first, else the byte arriving now
	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			q_valid  <= 1'b0;
			sh_valid <= 1'b0;
			sh_phase <= 2'd0;
		end else if (sh_load) begin
			sh_phase <= 2'd0;
			sh_valid <= q_valid | rd_rsp.rvalid;
			q_valid  <= q_valid & rd_rsp.rvalid;
		end else begin
			sh_phase <= sh_phase + 2'd1;
			if (rd_rsp.rvalid) begin
				q_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (rd_rsp.rvalid) begin
			q_data <= rd_rsp.rdata;
		end
		if (sh_load) begin
			sh_byte <= q_valid ? q_data : rd_rsp.rdata;
		end else begin
			sh_byte <= {sh_byte[5:0], 2'b00};
		end
	end

	// top pair of the shifter, first bit on re
	always_comb begin
		symbol.re = sh_byte[7] ? QPSK_NEG : QPSK_POS;
		symbol.im = sh_byte[6] ? QPSK_NEG : QPSK_POS;
	end

	assign symbol_oe = sh_valid;

	// a third stored packet would overwrite an unmapped slot
	a_no_overrun: assert property (@(posedge mpeg_clk) disable iff (!rst_n)
		pend_cnt <= 2'(BUF_PKTS));

endmodule

// ==== source/ts_crc_ingest.sv ====
`timescale 1ns/1ps

module ts_crc_ingest (
	input  logic                mpeg_clk,
	input  logic                rst_n,
	input  dvbs2_pkg::ts_in_t   ts_in,
	output dvbs2_pkg::mem_req_t wr_req,
	input  dvbs2_pkg::mem_rsp_t wr_rsp,
	output logic                pkt_stored
);
	import dvbs2_pkg::*;

	logic [7:0] byte_pos;
	logic [7:0] pos_in;
	logic [7:0] wr_pos;
	logic [7:0] byte_q;
	logic       wr_pend;
	logic       wr_slot;
	logic       seen_sync;
	logic [7:0] crc_run;
	logic [7:0] crc_last;
	logic [7:0] crc_next;

	// one byte through the crc register, msb first
	function automatic logic [7:0] crc8_byte(input logic [7:0] crc, input logic [7:0] d);
		logic [7:0] c;
		logic       fb;
		c = crc;
		for (int i = 7; i >= 0; i--) begin
			fb = c[7] ^ d[i];
			c = {c[6:0], 1'b0} ^ (fb ? CRC8_POLY : 8'h00);
		end
		return c;
	endfunction

	// sync forces position 0
	assign pos_in   = ts_in.sync ? 8'd0 : byte_pos;
	assign crc_next = crc8_byte(crc_run, byte_q);

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			byte_pos  <= 8'd0;
			wr_pend   <= 1'b0;
			seen_sync <= 1'b0;
		end else begin
			wr_pend <= ts_in.valid;
			if (ts_in.valid) begin
				byte_pos <= (pos_in == 8'(PKT_BYTES - 1)) ? 8'd0 : pos_in + 8'd1;
				if (ts_in.sync) begin
					seen_sync <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (ts_in.valid) begin
			byte_q <= ts_in.data;
			wr_pos <= pos_in;
		end
	end

	// crc runs over bytes 1..187, result held for the next sync slot
	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			crc_run  <= 8'h00;
			crc_last <= 8'h00;
			wr_slot  <= 1'b0;
		end else if (wr_pend) begin
			if (wr_pos == 8'd0) begin
				crc_run <= 8'h00;
			end else begin
				crc_run <= crc_next;
				if (wr_pos == 8'(PKT_BYTES - 1)) begin
					crc_last <= crc_next;
				end
			end
			if (pkt_stored) begin
				wr_slot <= ~wr_slot;
			end
		end
	end

	always_comb begin
		wr_req.req   = wr_pend;
		wr_req.we    = 1'b1;
		wr_req.addr  = wr_slot ? ADDR_W'(PKT_BYTES) + ADDR_W'(wr_pos) : ADDR_W'(wr_pos);
		// sync byte carries the crc of the previous packet
		wr_req.wdata = (wr_pos == 8'd0) ? crc_last : byte_q;
	end

	assign pkt_stored = wr_pend & wr_rsp.gnt & (wr_pos == 8'(PKT_BYTES - 1));

	a_sync_at_start: assert property (@(posedge mpeg_clk) disable iff (!rst_n)
		(ts_in.valid && ts_in.sync && seen_sync) |-> (byte_pos == 8'd0));

	// writer has priority in the buffer, so nothing may block it
	a_write_granted: assert property (@(posedge mpeg_clk) disable iff (!rst_n)
		wr_req.req |-> wr_rsp.gnt);

endmodule

// ==== tb/tb_dvbs2_mod.sv ====
`timescale 1ns/1ps

module tb_dvbs2_mod;
	import dvbs2_pkg::*;

	localparam int NUM_PKTS       = 4;
	localparam int REC_BYTES      = PKT_BYTES + 1;
	localparam int TOTAL_BYTES    = NUM_PKTS * PKT_BYTES;
	localparam int TOTAL_SYMS     = TOTAL_BYTES * 4;
	localparam int TIMEOUT_CYCLES = NUM_PKTS * PKT_BYTES * 8 + 2000;
	localparam int TAIL_CYCLES    = 200;

	logic       mpeg_clk;
	logic       rst_n;
	ts_in_t     ts_in;
	iq_symbol_t symbol;
	logic       symbol_oe;

	// per record: sync byte, 187 payload bytes, crc-8 of the payload
	logic [7:0] file_bytes [NUM_PKTS * REC_BYTES];
	logic [7:0] exp_bytes  [TOTAL_BYTES];
	integer     seed;
	int         sym_cnt = 0;
	int         cycle_cnt = 0;
	logic       first_pkt_sent = 1'b0;

	dvbs2_mod_top u_dut (
		.mpeg_clk  (mpeg_clk),
		.rst_n     (rst_n),
		.ts_in     (ts_in),
		.symbol    (symbol),
		.symbol_oe (symbol_oe)
	);

	initial begin
		mpeg_clk = 1'b0;
		forever begin
			#20 mpeg_clk = ~mpeg_clk;
		end
	end

	task automatic report_error(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_symbol(input iq_symbol_t got, input iq_symbol_t exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s: got (%h, %h), expected (%h, %h)",
				what, got.re, got.im, exp.re, exp.im));
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
		end
	endtask

	// pair p = 0 is the top pair, first bit on re, 0 maps to the positive level
	function automatic iq_symbol_t pair_symbol(input logic [7:0] b, input int p);
		iq_symbol_t s;
		s.re = b[7 - 2 * p] ? QPSK_NEG : QPSK_POS;
		s.im = b[6 - 2 * p] ? QPSK_NEG : QPSK_POS;
		return s;
	endfunction

	// sync slot of packet k holds the crc of packet k-1, zero for the first
	task automatic build_expected();
		for (int k = 0; k < NUM_PKTS; k++) begin
			for (int j = 0; j < PKT_BYTES; j++) begin
				if (j != 0) begin
					exp_bytes[k * PKT_BYTES + j] = file_bytes[k * REC_BYTES + j];
				end else if (k == 0) begin
					exp_bytes[k * PKT_BYTES] = 8'h00;
				end else begin
					exp_bytes[k * PKT_BYTES] = file_bytes[(k - 1) * REC_BYTES + PKT_BYTES];
				end
			end
		end
	endtask

	initial begin
		int gap;
		rst_n <= 1'b0;
		ts_in <= '0;
		seed = 84402;
		$readmemh("tb/testdata_ts.hex", file_bytes);
		if ($isunknown(file_bytes[0]) || $isunknown(file_bytes[NUM_PKTS * REC_BYTES - 1])) begin
			$display("test data file tb/testdata_ts.hex is missing or too short");
			$display("test failed");
			$fatal(1, "no stimulus");
		end
		build_expected();
		repeat (2) @(posedge mpeg_clk);
		rst_n <= 1'b1;
		for (int k = 0; k < NUM_PKTS; k++) begin
			for (int j = 0; j < PKT_BYTES; j++) begin
				// 4 to 7 cycles from one byte to the next
				gap = 4 + ($random(seed) & 3);
				@(posedge mpeg_clk);
				ts_in.valid <= 1'b1;
				ts_in.sync  <= (j == 0);
				ts_in.data  <= file_bytes[k * REC_BYTES + j];
				@(posedge mpeg_clk);
				ts_in.valid <= 1'b0;
				ts_in.sync  <= 1'b0;
				if (k == 0 && j == PKT_BYTES - 1) begin
					first_pkt_sent = 1'b1;
				end
				repeat (gap - 2) @(posedge mpeg_clk);
			end
		end
		wait (sym_cnt == TOTAL_SYMS);
		repeat (TAIL_CYCLES) @(posedge mpeg_clk);
		$display("test passed");
		$finish;
	end

	// outputs sampled mid cycle
	always @(negedge mpeg_clk) begin : watch_symbols
		int         byte_idx;
		iq_symbol_t exp_sym;
		if (!first_pkt_sent) begin
			if (symbol_oe !== 1'b0) begin
				report_error("symbol_oe active before the first packet was complete");
			end
		end else if (symbol_oe === 1'b1) begin
			if (sym_cnt >= TOTAL_SYMS) begin
				check_count(sym_cnt + 1, TOTAL_SYMS, "symbol after the last packet");
			end
			byte_idx = sym_cnt / 4;
			exp_sym  = pair_symbol(exp_bytes[byte_idx], sym_cnt % 4);
			check_symbol(symbol, exp_sym, $sformatf("packet %0d byte %0d (%s) pair %0d",
				byte_idx / PKT_BYTES, byte_idx % PKT_BYTES,
				(byte_idx % PKT_BYTES == 0) ? "crc slot" : "payload", sym_cnt % 4));
			sym_cnt = sym_cnt + 1;
		end else if (symbol_oe !== 1'b0) begin
			report_error("symbol_oe is unknown");
		end
	end

	always @(posedge mpeg_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: symbols missing (%0d of %0d seen)", sym_cnt, TOTAL_SYMS);
			$display("test failed");
			$fatal(1, "run exceeded %0d cycles", TIMEOUT_CYCLES);
		end
	end

endmodule

// ==== tb/testdata_ts.hex ====
// one ts packet per line: sync byte 47, payload bytes 1..187, then the expected crc-8
// crc-8 poly d5, init 00, msb first, over payload bytes 1..187 only
// payload is pairs (a, crc(a)) that clear the register, so the crc is that of the last byte
47 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 12 2D 34 08 56 4E 78 42 01 D5 3C 21
47 A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D A5 60 5A 99 F0 84 0F 7D 80 EF C3 D8
47 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 FF F9 00 00 81 3A 7E C3 10 52 55 E4
47 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 3C 21 C3 D8 99 41 66 B8 20 A4 AA 1D
